// File: Makefile
BIN = obj_dir/Vcore_exec_tb

all: run

# rebuilt only when a source, the model header or the file list changes.
$(BIN): sources.f $(wildcard src/core/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
	verilator --binary --assert --timescale 1ns/1ps -f sources.f --top-module core_exec_tb

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: sim/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// ###################################################################
// operand-2 shifter; the carry sits above the word in the result.

function automatic logic [32:0] shift_model(input word b, input shifter_control ctrl,
		input reg_shift amount, input logic c_in);
	int n;
	int r;
	word q;
	logic c;
	n = int'(amount);
	r = n % 32;
	q = b;
	c = c_in;
	if (ctrl.kind == shift_ror && ctrl.rrx && n == 0) begin
		q = {c_in, b[31:1]};
		c = b[0];
	end else if (n != 0) begin
		case (ctrl.kind)
			shift_lsl: begin
				q = n < 32 ? b << n : '0;
				c = n <= 32 ? b[32 - n] : 1'b0;
			end
			shift_lsr: begin
				q = n < 32 ? b >> n : '0;
				c = n <= 32 ? b[n - 1] : 1'b0;
			end
			shift_asr: begin
				q = n < 32 ? word'($signed(b) >>> n) : {32{b[31]}};
				c = n < 32 ? b[n - 1] : b[31];
			end
			default: begin
				q = r == 0 ? b : (b >> r) | (b << (32 - r));
				c = r == 0 ? b[31] : b[r - 1];
			end
		endcase
	end
	return {c, q};
endfunction

// returns overflow, carry and sum, with overflow judged on the signed values.
function automatic logic [33:0] add_carry(input word x, input word y, input logic cin);
	logic [32:0] full;
	longint s;
	full = {1'b0, x} + {1'b0, y} + 33'(cin);
	s = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
	return {s != longint'($signed(full[31:0])), full};
endfunction

// ###################################################################
// data-processing and multiply results

function automatic exec_result dp_model(input exec_req r);
	logic [32:0] sh;
	logic [33:0] ar;
	logic logic_op;
	exec_result e;
	sh = shift_model(r.b, r.shift, r.shift_amount, r.flags_in.c);
	ar = '0;
	logic_op = 1'b1;
	case (r.op)
		alu_and, alu_tst: e.q = r.a & sh[31:0];
		alu_eor, alu_teq: e.q = r.a ^ sh[31:0];
		alu_orr:          e.q = r.a | sh[31:0];
		alu_mov:          e.q = sh[31:0];
		alu_bic:          e.q = r.a & ~sh[31:0];
		alu_mvn:          e.q = ~sh[31:0];
		default: begin
			logic_op = 1'b0;
			case (r.op)
				alu_sub, alu_cmp: ar = add_carry(r.a, ~sh[31:0], 1'b1);
				alu_rsb:          ar = add_carry(sh[31:0], ~r.a, 1'b1);
				alu_add, alu_cmn: ar = add_carry(r.a, sh[31:0], 1'b0);
				alu_adc:          ar = add_carry(r.a, sh[31:0], r.flags_in.c);
				alu_sbc:          ar = add_carry(r.a, ~sh[31:0], r.flags_in.c);
				default:          ar = add_carry(sh[31:0], ~r.a, r.flags_in.c); // rsc.
			endcase
			e.q = ar[31:0];
		end
	endcase
	e.q_hi = '0;
	e.writes_q = !(r.op inside {alu_tst, alu_teq, alu_cmp, alu_cmn});
	e.flags = r.flags_in;
	if (r.set_flags) begin
		e.flags.n = e.q[31];
		e.flags.z = e.q == '0;
		e.flags.c = logic_op ? sh[32] : ar[32];
		e.flags.v = logic_op ? r.flags_in.v : ar[33];
	end
	return e;
endfunction

function automatic exec_result mul_model(input exec_req r);
	dword p;
	dword acc;
	exec_result e;
	if (r.mul.long_mul && r.mul.sig)
		p = dword'(longint'($signed(r.a)) * longint'($signed(r.b)));
	else
		p = dword'(r.a) * dword'(r.b);
	acc = '0;
	if (r.mul.add)
		acc = r.mul.long_mul ? {r.acc_hi, r.acc_lo} : dword'(r.acc_lo);
	p = p + acc;
	e.q = p[31:0];
	e.q_hi = p[63:32];
	e.writes_q = 1'b1;
	e.flags = r.flags_in; // c and v never move on a multiply.
	if (r.set_flags) begin
		e.flags.n = r.mul.long_mul ? p[63] : p[31];
		e.flags.z = r.mul.long_mul ? p == '0 : p[31:0] == '0;
	end
	return e;
endfunction

`endif

// File: sim/core_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_exec_tb
	import uarch_pkg::*, exec_pkg::*;
();

`include "exec_model.svh"

	logic clk = 1'b0;
	logic rst;
	logic issue;
	exec_req req;
	logic busy, done;
	exec_result res;

	integer seed = 22339;
	exec_result last_res = '0; // what res must hold until the next done.
	reg_shift edge_amounts [6] = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd255};

	core_exec uut (.*);

	always #10 clk = ~clk;

	// ###################################################################
	// checking

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_field(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		assert (got === exp)
		else abort_run($sformatf("FAIL %s got %0h expected %0h", name, got, exp));
	endtask

	task automatic start_op(input exec_req r);
		@(posedge clk);
		req <= r;
		issue <= 1'b1;
		@(posedge clk);
		issue <= 1'b0;
	endtask

	// counts falling edges from the issue edge until done shows up.
	task automatic wait_done(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > 40)
				abort_run("done never came within 40 cycles of the issue");
			if (!done) begin
				assert (busy) else abort_run("busy was low while an operation was running");
				check_field("res", 128'(res), 128'(last_res));
			end
		end while (!done);
		assert (!busy) else abort_run("busy was still high with done");
	endtask

	task automatic run_op(input exec_req r, output int cycles);
		exec_result exp;
		exp = r.is_mul ? mul_model(r) : dp_model(r);
		start_op(r);
		wait_done(cycles);
		check_field("q", 128'(res.q), 128'(exp.q));
		if (r.is_mul && r.mul.long_mul)
			check_field("q_hi", 128'(res.q_hi), 128'(exp.q_hi));
		check_field("writes_q", 128'(res.writes_q), 128'(exp.writes_q));
		check_field("flags", 128'(res.flags), 128'(exp.flags));
		if (r.is_mul) begin
			assert (cycles >= 3 && cycles <= 18)
			else abort_run($sformatf("a multiply took %0d cycles", cycles));
		end else begin
			assert (cycles == 2)
			else abort_run($sformatf("done came %0d cycles after issue, not 2", cycles));
		end
		last_res = res;
	endtask

	// ###################################################################
	// stimulus

	function automatic exec_req rand_dp();
		exec_req r;
		r = '0;
		r.op = alu_op'($unsigned($random(seed)) % 16);
		r.set_flags = 1'($random(seed));
		r.shift.kind = shift_type'($unsigned($random(seed)) % 3); // no ror here.
		r.shift_amount = reg_shift'($unsigned($random(seed)) % 36);
		r.a = word'($random(seed));
		r.b = word'($random(seed));
		r.flags_in = psr_flags'(4'($random(seed)));
		return r;
	endfunction

	// form 0 plain, 1 accumulate, 2 long unsigned, 3 long signed.
	function automatic exec_req rand_mul(input int form);
		exec_req r;
		r = '0;
		r.is_mul = 1'b1;
		r.set_flags = 1'($random(seed));
		r.a = word'($random(seed));
		r.b = word'($random(seed)) >> ($unsigned($random(seed)) % 32);
		r.acc_hi = word'($random(seed));
		r.acc_lo = word'($random(seed));
		r.mul.long_mul = form >= 2;
		r.mul.sig = form == 3;
		r.mul.add = form == 1 || (form >= 2 && 1'($random(seed)));
		if (r.mul.sig && 1'($random(seed)))
			r.b = ~r.b; // short runs of sign bits.
		r.flags_in = psr_flags'(4'($random(seed)));
		return r;
	endfunction

	initial begin
		exec_req r;
		int cycles;
		int small_cycles;
		int large_cycles;
		rst = 1'b1;
		issue = 1'b0;
		req = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_field("busy", 128'(busy), 128'(0));
		check_field("done", 128'(done), 128'(0));
		check_field("res", 128'(res), 128'(0));

		for (int i = 0; i < 96; i++) begin
			r = rand_dp();
			r.op = alu_op'(i % 16);
			run_op(r, cycles);
		end

		// shifter corner cases through a flag-setting mov.
		for (int k = 0; k < 4; k++)
			for (int i = 0; i < 6; i++)
				for (int j = 0; j < 2; j++) begin
					r = '0;
					r.op = alu_mov;
					r.set_flags = 1'b1;
					r.shift.kind = shift_type'(k);
					r.shift_amount = edge_amounts[i];
					r.b = j == 0 ? 32'h8000_0001 : word'($random(seed));
					r.flags_in = psr_flags'(4'($random(seed)));
					run_op(r, cycles);
				end
		for (int j = 0; j < 2; j++) begin
			r = '0;
			r.op = alu_mov;
			r.set_flags = 1'b1;
			r.shift.kind = shift_ror;
			r.shift.rrx = 1'b1;
			r.b = 32'h8000_0003;
			r.flags_in.c = 1'(j);
			run_op(r, cycles);
		end

		for (int i = 0; i < 64; i++)
			run_op(rand_mul(i % 4), cycles);
		r = rand_mul(0);
		r.b = 32'd3;
		run_op(r, small_cycles);
		r.b = '1;
		run_op(r, large_cycles);
		assert (small_cycles < large_cycles)
		else abort_run("a small multiplier did not finish before a large one");

		// data and multiply operations interleaved, each right after done.
		for (int i = 0; i < 24; i++) begin
			r = i % 2 == 1 ? rand_mul(i % 4) : rand_dp();
			run_op(r, cycles);
		end

		@(negedge clk);
		assert (!done) else abort_run("done stayed high for more than one cycle");
		check_field("res", 128'(res), 128'(last_res));
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
src/core/uarch_pkg.sv
src/core/exec_pkg.sv
src/core/core_shifter.sv
src/core/core_mul.sv
src/core/core_alu.sv
src/core/core_exec.sv
sim/core_exec_tb.sv

// File: src/core/core_alu.sv
`timescale 1ns/1ps
`default_nettype none

module core_alu
	import uarch_pkg::*, exec_pkg::*;
(
	input  logic       clk,
	                   rst,

	input  logic       issue,
	input  exec_req    req,

	input  word        op2,
	input  logic       c_shift,

	input  word        mul_q_hi,
	                   mul_q_lo,
	input  logic       mul_n,
	                   mul_z,
	                   mul_ready,
	output logic       mul_start,

	output logic       busy,
	                   done,
	output exec_result res
);

	alu_state state;
	exec_req held;

	word x, y, sum, q;
	logic cin, c_out, v_out, logic_op;
	psr_flags flags;
	exec_result dp_res, mul_res;

	// ###################################################################
	// data-processing datapath

	always_comb begin
		x = held.a;
		y = op2;
		cin = 1'b0;

		// subtraction is x + ~y + 1, with the carry as the inverted borrow.
		unique case (held.op)
			alu_sub, alu_cmp: begin
				y = ~op2;
				cin = 1'b1;
			end

			alu_rsb: begin
				x = op2;
				y = ~held.a;
				cin = 1'b1;
			end

			alu_adc:
				cin = held.flags_in.c;

			alu_sbc: begin
				y = ~op2;
				cin = held.flags_in.c;
			end

			alu_rsc: begin
				x = op2;
				y = ~held.a;
				cin = held.flags_in.c;
			end

			default: ;
		endcase

		{c_out, sum} = {1'b0, x} + {1'b0, y} + {{WORD_BITS{1'b0}}, cin};
		v_out = x[WORD_BITS-1] == y[WORD_BITS-1] && sum[WORD_BITS-1] != x[WORD_BITS-1];

		logic_op = 1'b1;
		unique case (held.op)
			alu_and, alu_tst: q = held.a & op2;
			alu_eor, alu_teq: q = held.a ^ op2;
			alu_orr:          q = held.a | op2;
			alu_mov:          q = op2;
			alu_bic:          q = held.a & ~op2;
			alu_mvn:          q = ~op2;
			default: begin
				q = sum;
				logic_op = 1'b0;
			end
		endcase

		flags = held.flags_in;
		if (held.set_flags) begin
			flags.n = q[WORD_BITS-1];
			flags.z = q == '0;
			flags.c = logic_op ? c_shift : c_out;
			flags.v = logic_op ? held.flags_in.v : v_out;
		end
	end

	assign dp_res.q = q;
	assign dp_res.q_hi = '0;
	assign dp_res.writes_q = !(held.op inside {alu_tst, alu_teq, alu_cmp, alu_cmn});
	assign dp_res.flags = flags;

	// multiplies only ever touch n and z.
	assign mul_res.q = mul_q_lo;
	assign mul_res.q_hi = mul_q_hi;
	assign mul_res.writes_q = 1'b1;
	assign mul_res.flags.n = held.set_flags ? mul_n : held.flags_in.n;
	assign mul_res.flags.z = held.set_flags ? mul_z : held.flags_in.z;
	assign mul_res.flags.c = held.flags_in.c;
	assign mul_res.flags.v = held.flags_in.v;

	// ###################################################################
	// sequencing

	// the multiplier samples its operands from req on this same edge.
	assign mul_start = issue && req.is_mul && state == idle;

	always_ff @(posedge clk)
		if (state == idle && issue)
			held <= req;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			busy <= 1'b0;
			done <= 1'b0;
			res <= '0;
		end else begin
			done <= 1'b0;

			unique case (state)
				idle:
					if (issue) begin
						state <= req.is_mul ? wait_mul : wait_shift;
						busy <= 1'b1;
					end

				wait_shift: begin // op2 is valid by now.
					state <= idle;
					busy <= 1'b0;
					done <= 1'b1;
					res <= dp_res;
				end

				wait_mul:
					if (mul_ready) begin
						state <= idle;
						busy <= 1'b0;
						done <= 1'b1;
						res <= mul_res;
					end

				default:
					state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/core/core_exec.sv
`timescale 1ns/1ps
`default_nettype none

module core_exec
	import uarch_pkg::*, exec_pkg::*;
(
	input  logic       clk,
	                   rst,

	input  logic       issue,
	input  exec_req    req,

	output logic       busy,
	                   done,
	output exec_result res
);

	word op2;
	logic c_shift;

	core_shifter shifter
	(
		.b(req.b),
		.ctrl(req.shift),
		.amount(req.shift_amount),
		.c_in(req.flags_in.c),
		.*
	);

	word mul_q_hi, mul_q_lo;
	logic mul_start, mul_n, mul_z, mul_ready;

	// operands are taken on the issue edge, the same one that latches req in the ALU.
	core_mul mult
	(
		.start(mul_start),
		.a(req.a),
		.b(req.b),
		.c_hi(req.acc_hi),
		.c_lo(req.acc_lo),
		.ctrl(req.mul),
		.q_hi(mul_q_hi),
		.q_lo(mul_q_lo),
		.n(mul_n),
		.z(mul_z),
		.ready(mul_ready),
		.*
	);

	core_alu alu
	(
		.*
	);

endmodule

`default_nettype wire

// File: src/core/core_mul.sv
`timescale 1ns/1ps
`default_nettype none

module core_mul
	import uarch_pkg::*, exec_pkg::*;
(
	input  logic       clk,
	                   rst,

	input  logic       start,
	input  word        a,
	                   b,
	                   c_hi,
	                   c_lo,
	input  mul_control ctrl,

	output word        q_hi,
	                   q_lo,
	output logic       n,
	                   z,
	                   ready
);

	mul_state state;
	mul_control ctrl_q;

	dword sum, mcand, acc;
	word mplier;

	dword cur_sum, cur_mcand, next_sum, product;
	word cur_mplier, next_mplier;
	logic sig, last, advance;

	// ###################################################################
	// one iteration of the shift-and-add loop

	// the first iteration runs on the start edge straight from the inputs.
	always_comb begin
		if (state == mul_idle) begin
			sig = ctrl.sig;
			cur_sum = '0;
			cur_mcand = {{WORD_BITS{ctrl.sig & a[WORD_BITS-1]}}, a};
			cur_mplier = b;
		end else begin
			sig = ctrl_q.sig;
			cur_sum = sum;
			cur_mcand = mcand;
			cur_mplier = mplier;
		end

		next_sum = cur_sum + cur_mcand * dword'(cur_mplier[MUL_BITS_PER_CYCLE-1:0]);
		next_mplier = {{MUL_BITS_PER_CYCLE{sig & cur_mplier[WORD_BITS-1]}},
		               cur_mplier[WORD_BITS-1:MUL_BITS_PER_CYCLE]};
	end

	// nothing left to add once the remaining bits are all zero or all sign.
	assign last = mplier == '0 || (ctrl_q.sig && mplier == '1);
	assign advance = state == mul_idle ? start : !last;

	// a remaining run of ones stands for -1 at the current weight.
	assign product = sum - (mplier[WORD_BITS-1] ? mcand : '0) + acc;

	always_ff @(posedge clk) begin
		if (advance) begin
			sum <= next_sum;
			mplier <= next_mplier;
			mcand <= cur_mcand << MUL_BITS_PER_CYCLE;
		end

		if (state == mul_idle && start) begin
			ctrl_q <= ctrl;
			if (ctrl.add)
				acc <= {ctrl.long_mul ? c_hi : word'(0), c_lo};
			else
				acc <= '0;
		end
	end

	// ###################################################################
	// control and the closing accumulate/flag cycle

	always_ff @(posedge clk) begin
		ready <= 1'b0;

		if (rst)
			state <= mul_idle;
		else unique case (state)
			mul_idle:
				if (start)
					state <= mul_run;

			mul_run:
				if (last) begin
					state <= mul_idle;
					ready <= 1'b1;

					q_hi <= product[DWORD_BITS-1:WORD_BITS];
					q_lo <= product[WORD_BITS-1:0];

					if (ctrl_q.long_mul) begin
						n <= product[DWORD_BITS-1];
						z <= product == '0;
					end else begin
						n <= product[WORD_BITS-1];
						z <= product[WORD_BITS-1:0] == '0;
					end
				end
		endcase
	end

endmodule

`default_nettype wire

// File: src/core/core_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module core_shifter
	import uarch_pkg::*;
(
	input  logic           clk,
	                       rst,

	input  logic           issue,
	input  word            b,
	input  shifter_control ctrl,
	input  reg_shift       amount,
	input  logic           c_in,

	output word            op2,
	output logic           c_shift
);

	word q;
	logic c;
	rot_amount rot;

	assign rot = amount[ROT_BITS-1:0];

	// the extra bit next to the word catches the last bit shifted out.
	always_comb begin
		q = b;
		c = c_in;

		if (ctrl.kind == shift_ror && ctrl.rrx && amount == '0) begin
			q = {c_in, b[WORD_BITS-1:1]};
			c = b[0];
		end else if (amount != '0) begin
			unique case (ctrl.kind)
				shift_lsl:
					{c, q} = {1'b0, b} << amount;

				shift_lsr:
					{q, c} = {b, 1'b0} >> amount;

				shift_asr:
					{q, c} = $signed({b, 1'b0}) >>> amount;

				shift_ror: begin
					// a multiple of 32 leaves b alone but still sets the carry.
					q = (b >> rot) | (b << (WORD_BITS - rot));
					c = q[WORD_BITS-1];
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			op2 <= '0;
			c_shift <= 1'b0;
		end else if (issue) begin
			op2 <= q; // held until the next issue.
			c_shift <= c;
		end
	end

endmodule

`default_nettype wire

// File: src/core/exec_pkg.sv
`default_nettype none

package exec_pkg;

	import uarch_pkg::*;

	// multiplier bits retired per iteration.
	localparam int MUL_BITS_PER_CYCLE = 2;

	typedef struct packed {
		logic long_mul;
		logic add;      // accumulate.
		logic sig;
	} mul_control;

	// ###################################################################
	// issue request and stage result

	typedef struct packed {
		logic           is_mul;
		alu_op          op;
		logic           set_flags;
		shifter_control shift;
		reg_shift       shift_amount;
		word            a;
		word            b;
		word            acc_hi;
		word            acc_lo;
		mul_control     mul;
		psr_flags       flags_in;
	} exec_req;

	typedef struct packed {
		word      q;
		word      q_hi;     // only meaningful after a long multiply.
		logic     writes_q;
		psr_flags flags;
	} exec_result;

	typedef enum logic [1:0] {
		idle,
		wait_shift,
		wait_mul
	} alu_state;

	typedef enum logic {
		mul_idle,
		mul_run
	} mul_state;

endpackage

`default_nettype wire

// File: src/core/uarch_pkg.sv
`default_nettype none

package uarch_pkg;

	// ###################################################################
	// widths

	localparam int WORD_BITS  = 32;
	localparam int DWORD_BITS = 2 * WORD_BITS;
	localparam int SHIFT_BITS = 8;
	localparam int ROT_BITS   = $clog2(WORD_BITS); // ror only looks at these bits.

	typedef logic [WORD_BITS-1:0]  word;
	typedef logic [DWORD_BITS-1:0] dword;
	typedef logic [SHIFT_BITS-1:0] reg_shift;
	typedef logic [ROT_BITS-1:0]   rot_amount;

	// ###################################################################
	// status flags and data-processing opcodes

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// opcode encoding follows bits 24:21 of the instruction.
	typedef enum logic [3:0] {
		alu_and = 4'b0000,
		alu_eor = 4'b0001,
		alu_sub = 4'b0010,
		alu_rsb = 4'b0011,
		alu_add = 4'b0100,
		alu_adc = 4'b0101,
		alu_sbc = 4'b0110,
		alu_rsc = 4'b0111,
		alu_tst = 4'b1000,
		alu_teq = 4'b1001,
		alu_cmp = 4'b1010,
		alu_cmn = 4'b1011,
		alu_orr = 4'b1100,
		alu_mov = 4'b1101,
		alu_bic = 4'b1110,
		alu_mvn = 4'b1111
	} alu_op;

	// ###################################################################
	// operand-2 shifter

	typedef enum logic [1:0] {
		shift_lsl = 2'b00,
		shift_lsr = 2'b01,
		shift_asr = 2'b10,
		shift_ror = 2'b11
	} shift_type;

	typedef struct packed {
		shift_type kind;
		logic      rrx;  // ror by zero becomes rotate through carry.
	} shifter_control;

endpackage

`default_nettype wire
